//--- hw/rv_decoder_pkg.sv
// Shared widths, word and register types, opcode, ALU-op, immediate-format and LSU control types
`default_nettype none

package rv_decoder_pkg;

    //////////////////////////////////////////////////
    // Widths and basic types
    //////////////////////////////////////////////////

    localparam int XLEN       = 32;    // Instruction and data width
    localparam int REG_ADDR_W = 5;     // x0..x31

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //////////////////////////////////////////////////
    // Major opcodes kept by the decoder
    //////////////////////////////////////////////////

    // Standard RV32I encodings, all end in 2'b11
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    //////////////////////////////////////////////////
    // ALU operation, {instr[30], funct3}
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    // Immediate layouts
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // Load/store control, store flag in bit 3 and funct3 below it
    typedef logic [3:0] lsu_ctrl_t;

endpackage

`default_nettype wire

//--- hw/rv_imm_gen.sv
// Immediate generator, reassembles and sign-extends the I, S, B, U and J immediates
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
    input  rv_decoder_pkg::data_t    instr_i,
    input  rv_decoder_pkg::imm_fmt_e fmt_i,
    output rv_decoder_pkg::data_t    imm_o
);

    import rv_decoder_pkg::*;

    logic sign;

    assign sign = instr_i[31];    // All formats take their sign from bit 31

    always_comb begin
        case (fmt_i)
            IMM_I: begin
                imm_o = {{20{sign}}, instr_i[31:20]};
            end
            IMM_S: begin
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            end
            IMM_B: begin
                // Branch offset, always even
                imm_o = {{19{sign}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {instr_i[31:12], 12'b0};    // Upper 20 bits, low 12 zero
            end
            IMM_J: begin
                // Jump offset, also even
                imm_o = {{11{sign}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;    // NONE
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rv_instr_decode.sv
// Instruction decoder, combinational opcode decode and the output register stage
`timescale 1ns/1ps
`default_nettype none

module rv_instr_decode (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  rv_decoder_pkg::data_t       instr_i,
    input  logic                        accept_i,
    output rv_decoder_pkg::imm_fmt_e    imm_fmt_o,
    input  rv_decoder_pkg::data_t       imm_i,
    // To the hazard unit
    output logic                        dec_rs1_used_o,
    output logic                        dec_rs2_used_o,
    output logic                        dec_wr_rd_o,
    output logic                        dec_illegal_o,
    output rv_decoder_pkg::reg_addr_t   dec_rs1_addr_o,
    output rv_decoder_pkg::reg_addr_t   dec_rs2_addr_o,
    output rv_decoder_pkg::reg_addr_t   dec_rd_addr_o,
    // Registered decode word
    output logic                        dec_valid_o,
    output logic                        illegal_o,
    output logic                        rs1_used_o,
    output logic                        rs2_used_o,
    output logic                        alu_wb_o,
    output logic                        lsu_valid_o,
    output rv_decoder_pkg::alu_op_e     alu_op_o,
    output rv_decoder_pkg::reg_addr_t   rs1_addr_o,
    output rv_decoder_pkg::reg_addr_t   rs2_addr_o,
    output rv_decoder_pkg::reg_addr_t   rd_addr_o,
    output rv_decoder_pkg::data_t       imm_o,
    output rv_decoder_pkg::lsu_ctrl_t   lsu_ctrl_o
);

    import rv_decoder_pkg::*;

    // Instruction fields
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       bit30;      // SUB/SRA select

    // Combinational decode results that only go into the output register
    alu_op_e    alu_op;
    logic       alu_wb;
    logic       lsu_valid;
    logic       is_store;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign bit30  = instr_i[30];

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////

    always_comb begin
        dec_illegal_o  = 1'b0;
        dec_rs1_used_o = 1'b0;
        dec_rs2_used_o = 1'b0;
        alu_wb         = 1'b0;
        lsu_valid      = 1'b0;
        is_store       = 1'b0;
        imm_fmt_o      = IMM_NONE;
        alu_op         = ALU_ADD;     // Address and link arithmetic

        case (opcode)
            OPC_OP: begin
                dec_rs1_used_o = 1'b1;
                dec_rs2_used_o = 1'b1;
                alu_wb         = 1'b1;
                alu_op         = alu_op_e'({bit30, funct3});
            end
            OPC_OP_IMM: begin
                dec_rs1_used_o = 1'b1;
                alu_wb         = 1'b1;
                imm_fmt_o      = IMM_I;
                // Bit 30 is part of the immediate except for SRLI/SRAI
                if (funct3 == 3'b101) begin
                    alu_op = alu_op_e'({bit30, funct3});
                end else begin
                    alu_op = alu_op_e'({1'b0, funct3});
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                alu_wb    = 1'b1;
                imm_fmt_o = IMM_U;
            end
            OPC_LOAD: begin
                dec_rs1_used_o = 1'b1;
                lsu_valid      = 1'b1;
                imm_fmt_o      = IMM_I;
            end
            OPC_STORE: begin
                dec_rs1_used_o = 1'b1;
                dec_rs2_used_o = 1'b1;
                lsu_valid      = 1'b1;
                is_store       = 1'b1;
                imm_fmt_o      = IMM_S;
            end
            OPC_BRANCH: begin
                dec_rs1_used_o = 1'b1;
                dec_rs2_used_o = 1'b1;
                imm_fmt_o      = IMM_B;
            end
            OPC_JAL: begin
                alu_wb    = 1'b1;
                imm_fmt_o = IMM_J;
            end
            OPC_JALR: begin
                dec_rs1_used_o = 1'b1;
                alu_wb         = 1'b1;
                imm_fmt_o      = IMM_I;
            end
            default: begin
                // Also catches compressed words, every kept opcode ends in 2'b11
                dec_illegal_o = 1'b1;
            end
        endcase
    end

    assign dec_wr_rd_o    = alu_wb | (lsu_valid & ~is_store);    // Loads write rd too
    assign dec_rs1_addr_o = dec_rs1_used_o ? instr_i[19:15] : '0;
    assign dec_rs2_addr_o = dec_rs2_used_o ? instr_i[24:20] : '0;
    assign dec_rd_addr_o  = dec_wr_rd_o    ? instr_i[11:7]  : '0;

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            dec_valid_o <= 1'b0;
            illegal_o   <= 1'b0;
            rs1_used_o  <= 1'b0;
            rs2_used_o  <= 1'b0;
            alu_wb_o    <= 1'b0;
            lsu_valid_o <= 1'b0;
            alu_op_o    <= ALU_ADD;
            rs1_addr_o  <= '0;
            rs2_addr_o  <= '0;
            rd_addr_o   <= '0;
            imm_o       <= '0;
            lsu_ctrl_o  <= '0;
        end else begin
            dec_valid_o <= accept_i;    // One pulse per accepted instruction
            if (accept_i) begin
                illegal_o   <= dec_illegal_o;
                rs1_used_o  <= dec_rs1_used_o;
                rs2_used_o  <= dec_rs2_used_o;
                alu_wb_o    <= alu_wb;
                lsu_valid_o <= lsu_valid;
                alu_op_o    <= alu_op;
                rs1_addr_o  <= dec_rs1_addr_o;
                rs2_addr_o  <= dec_rs2_addr_o;
                rd_addr_o   <= dec_rd_addr_o;
                imm_o       <= imm_i;
                lsu_ctrl_o  <= lsu_valid ? {is_store, funct3} : 4'b0000;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_hazard_unit.sv
// Read-after-write hazard unit, previous destination, one-cycle stall, ready and accept
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      instr_valid_i,
    input  logic                      rs1_used_i,
    input  logic                      rs2_used_i,
    input  logic                      wr_rd_i,
    input  logic                      illegal_i,
    input  rv_decoder_pkg::reg_addr_t rs1_addr_i,
    input  rv_decoder_pkg::reg_addr_t rs2_addr_i,
    input  rv_decoder_pkg::reg_addr_t rd_addr_i,
    output logic                      ready_o,
    output logic                      accept_o
);

    import rv_decoder_pkg::*;

    reg_addr_t prev_rd_q;     // Destination of the last accepted instruction, 0 if none
    logic      stalled_q;     // Bubble was issued last cycle
    logic      rs1_hit;
    logic      rs2_hit;
    logic      hazard;

    // x0 never creates a dependency
    assign rs1_hit = rs1_used_i && (rs1_addr_i != '0) && (rs1_addr_i == prev_rd_q);
    assign rs2_hit = rs2_used_i && (rs2_addr_i != '0) && (rs2_addr_i == prev_rd_q);
    assign hazard  = instr_valid_i && !illegal_i && (rs1_hit || rs2_hit);

    assign ready_o  = !(hazard && !stalled_q);    // At most one bubble per hazard
    assign accept_o = instr_valid_i && ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            prev_rd_q <= '0;
            stalled_q <= 1'b0;
        end else begin
            stalled_q <= !ready_o;
            if (accept_o) begin
                prev_rd_q <= wr_rd_i ? rd_addr_i : '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_decoder.sv
// RV32I decode stage top level, connects decoder, immediate generator and hazard unit
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  rv_decoder_pkg::data_t     instr_i,
    input  logic                      instr_valid_i,
    output logic                      ready_o,
    output logic                      dec_valid_o,
    output logic                      illegal_o,
    output rv_decoder_pkg::alu_op_e   alu_op_o,
    output logic                      rs1_used_o,
    output logic                      rs2_used_o,
    output rv_decoder_pkg::reg_addr_t rs1_addr_o,
    output rv_decoder_pkg::reg_addr_t rs2_addr_o,
    output rv_decoder_pkg::reg_addr_t rd_addr_o,
    output rv_decoder_pkg::data_t     imm_o,
    output logic                      alu_wb_o,
    output logic                      lsu_valid_o,
    output rv_decoder_pkg::lsu_ctrl_t lsu_ctrl_o
);

    import rv_decoder_pkg::*;

    imm_fmt_e  imm_fmt;
    data_t     imm;
    logic      accept;

    // Combinational decode towards the hazard unit
    logic      dec_rs1_used;
    logic      dec_rs2_used;
    logic      dec_wr_rd;
    logic      dec_illegal;
    reg_addr_t dec_rs1_addr;
    reg_addr_t dec_rs2_addr;
    reg_addr_t dec_rd_addr;

    rv_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    rv_instr_decode u_decode (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_i        (instr_i),
        .accept_i       (accept),
        .imm_fmt_o      (imm_fmt),
        .imm_i          (imm),
        .dec_rs1_used_o (dec_rs1_used),
        .dec_rs2_used_o (dec_rs2_used),
        .dec_wr_rd_o    (dec_wr_rd),
        .dec_illegal_o  (dec_illegal),
        .dec_rs1_addr_o (dec_rs1_addr),
        .dec_rs2_addr_o (dec_rs2_addr),
        .dec_rd_addr_o  (dec_rd_addr),
        .dec_valid_o    (dec_valid_o),
        .illegal_o      (illegal_o),
        .rs1_used_o     (rs1_used_o),
        .rs2_used_o     (rs2_used_o),
        .alu_wb_o       (alu_wb_o),
        .lsu_valid_o    (lsu_valid_o),
        .alu_op_o       (alu_op_o),
        .rs1_addr_o     (rs1_addr_o),
        .rs2_addr_o     (rs2_addr_o),
        .rd_addr_o      (rd_addr_o),
        .imm_o          (imm_o),
        .lsu_ctrl_o     (lsu_ctrl_o)
    );

    rv_hazard_unit u_hazard (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .rs1_used_i    (dec_rs1_used),
        .rs2_used_i    (dec_rs2_used),
        .wr_rd_i       (dec_wr_rd),
        .illegal_i     (dec_illegal),
        .rs1_addr_i    (dec_rs1_addr),
        .rs2_addr_i    (dec_rs2_addr),
        .rd_addr_i     (dec_rd_addr),
        .ready_o       (ready_o),
        .accept_o      (accept)
    );

endmodule

`default_nettype wire

//--- test/tb_rv_decoder_model.svh
// Reference model of the decoder: opcode legality, immediate assembly and field decode
`ifndef TB_RV_DECODER_MODEL_SVH
`define TB_RV_DECODER_MODEL_SVH

// Only the nine kept major opcodes are legal, low bits included
function automatic logic model_legal(input data_t w);
    logic [6:0] opc;
    opc = w[6:0];
    return (opc == OPC_OP)     || (opc == OPC_OP_IMM) || (opc == OPC_LUI)   ||
           (opc == OPC_AUIPC)  || (opc == OPC_LOAD)   || (opc == OPC_STORE) ||
           (opc == OPC_BRANCH) || (opc == OPC_JAL)    || (opc == OPC_JALR);
endfunction

function automatic data_t model_imm(input data_t w, input imm_fmt_e fmt);
    case (fmt)
        IMM_I:   return {{20{w[31]}}, w[31:20]};
        IMM_S:   return {{20{w[31]}}, w[31:25], w[11:7]};
        IMM_B:   return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        IMM_U:   return {w[31:12], 12'h000};
        IMM_J:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default: return '0;
    endcase
endfunction

// Expected decode word for one instruction
task automatic model_decode(input data_t w, output logic illegal, output logic rs1_used,
                            output logic rs2_used, output logic alu_wb,
                            output logic lsu_valid, output alu_op_e alu_op,
                            output reg_addr_t rs1_addr, output reg_addr_t rs2_addr,
                            output reg_addr_t rd_addr, output data_t imm,
                            output lsu_ctrl_t lsu_ctrl);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       is_load;
    logic       is_store;
    imm_fmt_e   fmt;
    opc       = w[6:0];
    f3        = w[14:12];
    illegal   = !model_legal(w);
    is_load   = (opc == OPC_LOAD);
    is_store  = (opc == OPC_STORE);
    rs1_used  = (opc == OPC_OP) || (opc == OPC_OP_IMM) || is_load || is_store ||
                (opc == OPC_BRANCH) || (opc == OPC_JALR);
    rs2_used  = (opc == OPC_OP) || is_store || (opc == OPC_BRANCH);
    alu_wb    = (opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LUI) ||
                (opc == OPC_AUIPC) || (opc == OPC_JAL) || (opc == OPC_JALR);
    lsu_valid = is_load || is_store;
    rs1_addr  = rs1_used ? w[19:15] : 5'd0;
    rs2_addr  = rs2_used ? w[24:20] : 5'd0;
    rd_addr   = (alu_wb || is_load) ? w[11:7] : 5'd0;    // Stores and branches write nothing
    lsu_ctrl  = lsu_valid ? {is_store, f3} : 4'd0;
    if ((opc == OPC_OP_IMM) || is_load || (opc == OPC_JALR)) fmt = IMM_I;
    else if (is_store)                                        fmt = IMM_S;
    else if (opc == OPC_BRANCH)                               fmt = IMM_B;
    else if ((opc == OPC_LUI) || (opc == OPC_AUIPC))          fmt = IMM_U;
    else if (opc == OPC_JAL)                                  fmt = IMM_J;
    else                                                      fmt = IMM_NONE;
    imm = model_imm(w, fmt);
    if (opc == OPC_OP) alu_op = alu_op_e'({w[30], f3});
    else if (opc == OPC_OP_IMM) alu_op = alu_op_e'({(f3 == 3'b101) & w[30], f3});
    else alu_op = ALU_ADD;
endtask

`endif

//--- test/tb_rv_decoder.sv
// Testbench for the RV32I decode stage with random instructions checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder;

    import rv_decoder_pkg::*;

    localparam int N_INSTR     = 400;
    localparam int CLK_HALF_NS = 20;
    localparam int CLK_NS      = 2 * CLK_HALF_NS;

    logic      clk_i, rstn_i, instr_valid_i;
    data_t     instr_i;
    logic      ready_o, dec_valid_o, illegal_o, rs1_used_o, rs2_used_o, alu_wb_o, lsu_valid_o;
    alu_op_e   alu_op_o;
    reg_addr_t rs1_addr_o, rs2_addr_o, rd_addr_o;
    data_t     imm_o;
    lsu_ctrl_t lsu_ctrl_o;

    integer    seed;
    reg_addr_t prev_rd_m;       // Model of the stored destination
    logic      stall_m;
    logic      exp_dv;          // Accept seen last cycle
    logic      have_last;       // Output register loaded at least once
    data_t     last_instr;
    data_t     accepted_q[$];

    `include "tb_rv_decoder_model.svh"

    rv_decoder uut (
        .clk_i (clk_i), .rstn_i (rstn_i), .instr_i (instr_i), .instr_valid_i (instr_valid_i),
        .ready_o (ready_o), .dec_valid_o (dec_valid_o), .illegal_o (illegal_o),
        .alu_op_o (alu_op_o), .rs1_used_o (rs1_used_o), .rs2_used_o (rs2_used_o),
        .rs1_addr_o (rs1_addr_o), .rs2_addr_o (rs2_addr_o), .rd_addr_o (rd_addr_o),
        .imm_o (imm_o), .alu_wb_o (alu_wb_o), .lsu_valid_o (lsu_valid_o),
        .lsu_ctrl_o (lsu_ctrl_o)
    );

    always #CLK_HALF_NS clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_logic(input string name, input logic got, input logic exp);
        if (got !== exp) stop_on_error($sformatf("ERR %0t ns %s got %b expected %b",
                                                 $time, name, got, exp));
    endtask

    task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp) stop_on_error($sformatf("ERR %0t ns %s got %h expected %h",
                                                 $time, name, got, exp));
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) stop_on_error($sformatf("ERR %0t ns %s got %0d expected %0d",
                                                 $time, name, got, exp));
    endtask

    task automatic check_imm(input string name, input data_t got, input data_t exp);
        if (got !== exp) stop_on_error($sformatf("ERR %0t ns %s got %h expected %h",
                                                 $time, name, got, exp));
    endtask

    task automatic check_lsu(input string name, input lsu_ctrl_t got, input lsu_ctrl_t exp);
        if (got !== exp) stop_on_error($sformatf("ERR %0t ns %s got %h expected %h",
                                                 $time, name, got, exp));
    endtask

    // Registered fields hold the last accepted word and are all zero after reset
    task automatic check_word();
        logic      e_ill, e_rs1u, e_rs2u, e_wb, e_lsuv;
        alu_op_e   e_alu;
        reg_addr_t e_rs1, e_rs2, e_rd;
        data_t     e_imm;
        lsu_ctrl_t e_lsu;
        model_decode(have_last ? last_instr : 32'h0000_0033, e_ill, e_rs1u, e_rs2u, e_wb,
                     e_lsuv, e_alu, e_rs1, e_rs2, e_rd, e_imm, e_lsu);
        if (!have_last) begin
            {e_ill, e_rs1u, e_rs2u, e_wb, e_lsuv} = '0;
        end
        check_logic("illegal_o", illegal_o, e_ill);
        check_logic("rs1_used_o", rs1_used_o, e_rs1u);
        check_logic("rs2_used_o", rs2_used_o, e_rs2u);
        check_logic("alu_wb_o", alu_wb_o, e_wb);
        check_logic("lsu_valid_o", lsu_valid_o, e_lsuv);
        check_alu_op("alu_op_o", alu_op_o, e_alu);
        check_reg("rs1_addr_o", rs1_addr_o, e_rs1);
        check_reg("rs2_addr_o", rs2_addr_o, e_rs2);
        check_reg("rd_addr_o", rd_addr_o, e_rd);
        check_imm("imm_o", imm_o, e_imm);
        check_lsu("lsu_ctrl_o", lsu_ctrl_o, e_lsu);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[10:8] != 3'b000) return {3'b000, r[1:0]};    // Mostly x0..x3
        return r[4:0];
    endfunction

    task automatic build_instr(output data_t w);
        logic [31:0] r;
        logic [6:0]  opc;
        w = $random(seed);    // Random funct3, bit 30 and immediate bits
        r = $random(seed);
        case (r[7:0] % 12)
            0:       opc = OPC_OP;
            1:       opc = OPC_OP_IMM;
            2:       opc = OPC_LUI;
            3:       opc = OPC_AUIPC;
            4:       opc = OPC_LOAD;
            5:       opc = OPC_STORE;
            6:       opc = OPC_BRANCH;
            7:       opc = OPC_JAL;
            8:       opc = OPC_JALR;
            9:       opc = 7'b0001111;          // MISC-MEM
            10:      opc = 7'b1110011;          // SYSTEM
            default: opc = {w[6:1], 1'b0};      // Low bits never 11
        endcase
        w[6:0]   = opc;
        w[11:7]  = pick_reg();
        w[19:15] = pick_reg();
        w[24:20] = pick_reg();
    endtask

    initial begin
        data_t       w;
        logic [31:0] r;
        logic        holding, hazard, exp_ready, accept;
        logic        m_ill, m_rs1u, m_rs2u, m_wb, m_lsuv;
        alu_op_e     m_alu;
        reg_addr_t   m_rs1, m_rs2, m_rd;
        data_t       m_imm;
        lsu_ctrl_t   m_lsu;
        int          n_issued, n_checked;
        seed = 26;
        clk_i = 1'b0;
        rstn_i = 1'b0;
        instr_i = '0;
        instr_valid_i = 1'b0;
        prev_rd_m = '0;
        stall_m = 1'b0;
        exp_dv = 1'b0;
        have_last = 1'b0;
        holding = 1'b0;
        n_issued = 0;
        n_checked = 0;
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        while (n_checked < N_INSTR) begin
            @(posedge clk_i);
            if (!holding) begin
                r = $random(seed);
                if ((n_issued < N_INSTR) && (r[1:0] != 2'b00)) begin
                    build_instr(w);
                    holding = 1'b1;
                    n_issued++;
                    instr_valid_i <= 1'b1;
                    instr_i       <= w;
                end else begin
                    instr_valid_i <= 1'b0;
                    instr_i       <= $random(seed);    // Junk that the DUT must ignore
                end
            end
            @(negedge clk_i);
            model_decode(instr_i, m_ill, m_rs1u, m_rs2u, m_wb, m_lsuv, m_alu, m_rs1, m_rs2,
                         m_rd, m_imm, m_lsu);
            hazard = instr_valid_i && !m_ill &&
                     ((m_rs1u && (m_rs1 != 0) && (m_rs1 == prev_rd_m)) ||
                      (m_rs2u && (m_rs2 != 0) && (m_rs2 == prev_rd_m)));
            exp_ready = !(hazard && !stall_m);
            check_logic("ready_o", ready_o, exp_ready);
            check_logic("dec_valid_o", dec_valid_o, exp_dv);
            if (exp_dv) begin
                last_instr = accepted_q.pop_front();
                have_last  = 1'b1;
                n_checked++;
            end
            check_word();
            accept  = instr_valid_i && exp_ready;
            stall_m = !exp_ready;
            exp_dv  = accept;
            if (accept) begin
                accepted_q.push_back(instr_i);
                prev_rd_m = m_rd;    // Already 0 when rd is not written
                holding   = 1'b0;
            end
        end
        $display("** PASS **");
        $finish;
    end

    // Watchdog allows four cycles per instruction plus margin
    initial begin
        #((N_INSTR * 4 + 100) * CLK_NS);
        stop_on_error("Timeout: the decoder did not finish the instruction stream in time");
    end

endmodule

`default_nettype wire

//--- rv_decoder.f
+incdir+test
hw/rv_decoder_pkg.sv
hw/rv_imm_gen.sv
hw/rv_instr_decode.sv
hw/rv_hazard_unit.sv
hw/rv_decoder.sv
test/tb_rv_decoder.sv
